/* hw/gl_isa_pkg.sv */
`default_nettype none

package gl_isa_pkg;

    localparam int CMD_W  = 32;
    localparam int MEM_AW = 8;                        // 256 command words
    localparam int BUS_AW = 9;                        // word address on the bus

    localparam int               CTRL_SEL_BIT = BUS_AW - 1; // high half is control space
    localparam logic [BUS_AW-2:0] CTRL_STATUS = '0;         // start / busy register

    ////////////////////
    // opcodes, low byte of the first word
    localparam logic [7:0] OP_NOP       = 8'h00;
    localparam logic [7:0] OP_VP_ORIGIN = 8'h01;
    localparam logic [7:0] OP_VP_SIZE   = 8'h02;
    localparam logic [7:0] OP_COLOR     = 8'h03;
    localparam logic [7:0] OP_VERTEX    = 8'h04;
    localparam logic [7:0] OP_FLUSH     = 8'h05;
    localparam logic [7:0] OP_END       = 8'hff;

    // opcode word or coordinate operand word, same 32 bits
    typedef union packed {
        struct packed {
            logic        typ;
            logic [22:0] imm;
            logic [7:0]  opcode;
        } op;
        struct packed {
            logic signed [15:0] x;
            logic signed [15:0] y;
        } coord;
    } cmd_word_t;

endpackage

`default_nettype wire

/* hw/gl_geom_pkg.sv */
`default_nettype none

package gl_geom_pkg;

    localparam int COORD_W   = 16;
    localparam int FRAC_BITS = 14;                    // normalized coords are Q1.14
    localparam int COLOR_W   = 16;                    // rgb555 in bits 14:0

    ////////////////////
    // vertex entry: color | z | screen y | screen x
    localparam int ENTRY_W = 64;

    localparam logic [ENTRY_W-1:0] FLUSH_ENTRY = '1;

    ////////////////////
    // fifo sizing
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;                    // log2 of the depth

    // items that can sit in the transform between a room check and the write
    localparam int XFORM_STAGES = 2;

endpackage

`default_nettype wire

/* hw/wb_host_port.sv */
`default_nettype none

module wb_host_port import gl_isa_pkg::*; (
    input  logic              clk1,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [BUS_AW-1:0] adr,
    input  logic [CMD_W-1:0]  dat_w,
    output logic [CMD_W-1:0]  dat_r,
    output logic              ack,
    output logic              mem_we,
    output logic [MEM_AW-1:0] mem_addr,
    output logic [CMD_W-1:0]  mem_data,
    output logic              start,
    input  logic              done,
    output logic              busy
);

    logic req;                                        // new cycle, not yet acked
    logic ctrl_hit;
    logic start_hit;

    assign req       = cyc && stb && !ack;
    assign ctrl_hit  = adr[CTRL_SEL_BIT] && (adr[BUS_AW-2:0] == CTRL_STATUS);
    assign start_hit = req && we && ctrl_hit && dat_w[0] && !busy;

    // memory writes go straight through in the request cycle
    assign mem_we   = req && we && !adr[CTRL_SEL_BIT];
    assign mem_addr = adr[MEM_AW-1:0];
    assign mem_data = dat_w;

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            ack   <= 1'b0;
            start <= 1'b0;
            busy  <= 1'b0;
        end
        else
        begin
            ack   <= req;
            start <= start_hit;
            if (start_hit)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
        end
    end

    // only status reads back, memory region reads as zero
    always_ff @(posedge clk1)
    begin
        if (req)
            dat_r <= ctrl_hit ? {{(CMD_W-1){1'b0}}, busy} : '0;
    end

    ack_needs_stb: assert property (@(posedge clk1) disable iff (reset) ack |-> stb);

endmodule

`default_nettype wire

/* hw/cmd_mem.sv */
`default_nettype none

module cmd_mem import gl_isa_pkg::*; (
    input  logic              clk1,
    input  logic              we,
    input  logic [MEM_AW-1:0] waddr,
    input  logic [CMD_W-1:0]  wdata,
    input  logic [MEM_AW-1:0] rd_addr,
    output logic [CMD_W-1:0]  rd_data
);

    logic [CMD_W-1:0] mem [1<<MEM_AW];

    always_ff @(posedge clk1)
    begin
        if (we)
            mem[waddr] <= wdata;                      // host side
        rd_data <= mem[rd_addr];                      // fetch side, one cycle
    end

endmodule

`default_nettype wire

/* hw/cmd_fetch.sv */
`default_nettype none

module cmd_fetch import gl_isa_pkg::*; (
    input  logic              clk1,
    input  logic              reset,
    input  logic              start,
    output logic [MEM_AW-1:0] rd_addr,
    input  logic [CMD_W-1:0]  rd_data,
    output cmd_word_t         cmd_word,
    output logic              cmd_valid,
    input  logic              cmd_take,
    output logic              done
);

    logic [MEM_AW-1:0] pc;
    logic              operand_next;                  // next word is an operand, not an opcode
    logic              last_word;

    // memory output is the word, it holds while the address holds
    assign cmd_word  = rd_data;
    assign last_word = cmd_take && !operand_next && (cmd_word.op.opcode == OP_END);

    always_comb
    begin
        if (start)
            rd_addr = '0;
        else if (cmd_take)
            rd_addr = pc + 1'b1;                      // prefetch next word
        else
            rd_addr = pc;
    end

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            pc           <= '0;
            cmd_valid    <= 1'b0;
            operand_next <= 1'b0;
            done         <= 1'b0;
        end
        else
        begin
            done <= last_word;
            if (start)
            begin
                pc           <= '0;
                cmd_valid    <= 1'b1;
                operand_next <= 1'b0;
            end
            else if (cmd_take)
            begin
                pc <= pc + 1'b1;
                if (last_word)
                    cmd_valid <= 1'b0;                // stop on END
                operand_next <= !operand_next &&
                    (cmd_word.op.opcode inside {OP_VP_ORIGIN, OP_VP_SIZE, OP_VERTEX});
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cmd_decode.sv */
`default_nettype none

module cmd_decode import gl_isa_pkg::*, gl_geom_pkg::*; (
    input  logic                      clk1,
    input  logic                      reset,
    input  cmd_word_t                 cmd_word,
    input  logic                      cmd_valid,
    output logic                      cmd_take,
    input  logic                      room,
    output logic                      vtx_valid,
    output logic                      flush_req,
    output logic signed [COORD_W-1:0] vtx_x,
    output logic signed [COORD_W-1:0] vtx_y,
    output logic        [COORD_W-1:0] vtx_z,
    output logic        [COLOR_W-1:0] vtx_color,
    output logic signed [COORD_W-1:0] vp_x,
    output logic signed [COORD_W-1:0] vp_y,
    output logic signed [COORD_W-1:0] vp_hw,
    output logic signed [COORD_W-1:0] vp_hh
);

    logic       wait_operand;                         // opcode seen, operand word next
    logic [7:0] pend_op;
    logic [7:0] op;
    logic       needs_room;

    assign op = cmd_word.op.opcode;

    // only words that end up in the fifo wait on room
    always_comb
    begin
        if (wait_operand)
            needs_room = (pend_op == OP_VERTEX);
        else
            needs_room = (op == OP_VERTEX) || (op == OP_FLUSH);
    end

    assign cmd_take  = cmd_valid && (room || !needs_room);
    assign vtx_valid = cmd_take && wait_operand && (pend_op == OP_VERTEX);
    assign flush_req = cmd_take && !wait_operand && (op == OP_FLUSH);

    assign vtx_x = cmd_word.coord.x;
    assign vtx_y = cmd_word.coord.y;

    ////////////////////
    // state and render registers
    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            wait_operand <= 1'b0;
            pend_op      <= OP_NOP;
            vtx_color    <= '0;
            vp_x         <= '0;
            vp_y         <= '0;
            vp_hw        <= '0;
            vp_hh        <= '0;
        end
        else if (cmd_take)
        begin
            if (wait_operand)
            begin
                wait_operand <= 1'b0;
                case (pend_op)
                    OP_VP_ORIGIN:
                    begin
                        vp_x <= cmd_word.coord.x;
                        vp_y <= cmd_word.coord.y;
                    end
                    OP_VP_SIZE:
                    begin
                        vp_hw <= cmd_word.coord.x;    // half width
                        vp_hh <= cmd_word.coord.y;    // half height
                    end
                    default: ;                        // vertex already issued
                endcase
            end
            else
            begin
                case (op)
                    OP_VP_ORIGIN, OP_VP_SIZE, OP_VERTEX:
                    begin
                        wait_operand <= 1'b1;
                        pend_op      <= op;
                    end
                    OP_COLOR: vtx_color <= {1'b0, cmd_word.op.imm[COLOR_W-2:0]};
                    default: ;                        // nop, flush, end
                endcase
            end
        end
    end

    // depth rides in the opcode word of VERTEX
    always_ff @(posedge clk1)
    begin
        if (cmd_take && !wait_operand)
            vtx_z <= cmd_word.op.imm[COORD_W-1:0];
    end

    // a presented word stays put until it is taken
    word_held: assert property (@(posedge clk1) disable iff (reset)
        (cmd_valid && !cmd_take) |=> (cmd_valid && $stable(cmd_word)));

endmodule

`default_nettype wire

/* hw/viewport_xform.sv */
`default_nettype none

module viewport_xform import gl_geom_pkg::*; (
    input  logic                      clk1,
    input  logic                      reset,
    input  logic                      vtx_valid,
    input  logic                      flush_req,
    input  logic signed [COORD_W-1:0] vtx_x,
    input  logic signed [COORD_W-1:0] vtx_y,
    input  logic        [COORD_W-1:0] vtx_z,
    input  logic        [COLOR_W-1:0] vtx_color,
    input  logic signed [COORD_W-1:0] vp_x,
    input  logic signed [COORD_W-1:0] vp_y,
    input  logic signed [COORD_W-1:0] vp_hw,
    input  logic signed [COORD_W-1:0] vp_hh,
    output logic                      fifo_we,
    output logic        [ENTRY_W-1:0] fifo_din
);

    logic                        s1_valid;
    logic                        s1_flush;
    logic signed [2*COORD_W-1:0] s1_px;               // x * half width, Q.14
    logic signed [2*COORD_W-1:0] s1_py;
    logic signed [COORD_W-1:0]   s1_vpx;
    logic signed [COORD_W-1:0]   s1_vpy;
    logic signed [COORD_W-1:0]   s1_hw;
    logic signed [COORD_W-1:0]   s1_hh;
    logic        [COORD_W-1:0]   s1_z;
    logic        [COLOR_W-1:0]   s1_color;
    logic signed [2*COORD_W-1:0] sx;
    logic signed [2*COORD_W-1:0] sy;

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            s1_flush <= 1'b0;
            fifo_we  <= 1'b0;
        end
        else
        begin
            s1_valid <= vtx_valid;
            s1_flush <= flush_req;
            fifo_we  <= s1_valid || s1_flush;
        end
    end

    ////////////////////
    // stage one, multiply
    always_ff @(posedge clk1)
    begin
        s1_px    <= vtx_x * vp_hw;
        s1_py    <= vtx_y * vp_hh;
        s1_vpx   <= vp_x;                             // viewport captured per vertex
        s1_vpy   <= vp_y;
        s1_hw    <= vp_hw;
        s1_hh    <= vp_hh;
        s1_z     <= vtx_z;
        s1_color <= vtx_color;
    end

    ////////////////////
    // stage two, offset and pack
    always_comb
    begin
        sx = s1_vpx + s1_hw + (s1_px >>> FRAC_BITS);
        sy = s1_vpy + s1_hh + (s1_py >>> FRAC_BITS);
    end

    always_ff @(posedge clk1)
    begin
        fifo_din <= s1_flush ? FLUSH_ENTRY
                             : {s1_color, s1_z, sy[COORD_W-1:0], sx[COORD_W-1:0]};
    end

endmodule

`default_nettype wire

/* hw/vertex_fifo.sv */
`default_nettype none

module vertex_fifo import gl_geom_pkg::*; (
    input  logic               clk1,
    input  logic               reset,
    input  logic               we,
    input  logic [ENTRY_W-1:0] din,
    input  logic               rd_en,
    output logic [ENTRY_W-1:0] dout,
    output logic               empty,
    output logic               room
);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wptr;
    logic [FIFO_AW-1:0] rptr;
    logic [FIFO_AW:0]   count;
    logic               pop;

    assign pop   = rd_en && !empty;
    assign empty = (count == '0);
    assign dout  = mem[rptr];                         // head shown while not empty

    // leave space for whatever is still in the transform
    assign room = (count + XFORM_STAGES) < FIFO_DEPTH;

    always_ff @(posedge clk1)
    begin
        if (we)
            mem[wptr] <= din;
    end

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end
        else
        begin
            if (we)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;
            case ({we, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                            // both or neither
            endcase
        end
    end

    no_write_when_full: assert property (@(posedge clk1) disable iff (reset)
        we |-> (count < FIFO_DEPTH));

endmodule

`default_nettype wire

/* hw/gl_core.sv */
`default_nettype none

module gl_core import gl_isa_pkg::*, gl_geom_pkg::*; (
    input  logic               clk1,
    input  logic               reset,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [BUS_AW-1:0]  adr,
    input  logic [CMD_W-1:0]   dat_w,
    output logic [CMD_W-1:0]   dat_r,
    output logic               ack,
    input  logic               rd_en,
    output logic [ENTRY_W-1:0] dout,
    output logic               empty
);

    logic                      mem_we;
    logic [MEM_AW-1:0]         mem_addr;
    logic [CMD_W-1:0]          mem_data;
    logic                      start;
    logic                      done;
    logic [MEM_AW-1:0]         rd_addr;
    logic [CMD_W-1:0]          rd_data;
    cmd_word_t                 cmd_word;
    logic                      cmd_valid;
    logic                      cmd_take;
    logic                      room;
    logic                      vtx_valid;
    logic                      flush_req;
    logic signed [COORD_W-1:0] vtx_x, vtx_y;
    logic        [COORD_W-1:0] vtx_z;
    logic        [COLOR_W-1:0] vtx_color;
    logic signed [COORD_W-1:0] vp_x, vp_y, vp_hw, vp_hh;
    logic                      fifo_we;
    logic        [ENTRY_W-1:0] fifo_din;

    ////////////////////
    // host side
    wb_host_port u_host (.clk1, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
                         .mem_we, .mem_addr, .mem_data, .start, .done, .busy());

    cmd_mem u_mem (.clk1, .we(mem_we), .waddr(mem_addr), .wdata(mem_data),
                   .rd_addr, .rd_data);

    ////////////////////
    // command pipeline
    cmd_fetch u_fetch (.clk1, .reset, .start, .rd_addr, .rd_data,
                       .cmd_word, .cmd_valid, .cmd_take, .done);

    cmd_decode u_decode (.clk1, .reset, .cmd_word, .cmd_valid, .cmd_take, .room,
                         .vtx_valid, .flush_req, .vtx_x, .vtx_y, .vtx_z, .vtx_color,
                         .vp_x, .vp_y, .vp_hw, .vp_hh);

    viewport_xform u_xform (.clk1, .reset, .vtx_valid, .flush_req, .vtx_x, .vtx_y,
                            .vtx_z, .vtx_color, .vp_x, .vp_y, .vp_hw, .vp_hh,
                            .fifo_we, .fifo_din);

    vertex_fifo u_fifo (.clk1, .reset, .we(fifo_we), .din(fifo_din),
                        .rd_en, .dout, .empty, .room);

endmodule

`default_nettype wire

/* test/tb_gl_core.sv */
`default_nettype none

module tb_gl_core
    import gl_isa_pkg::*, gl_geom_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [BUS_AW-1:0] CTRL_ADDR = {1'b1, CTRL_STATUS};
    localparam int ACK_LIMIT    = 16;                 // cycles per bus cycle
    localparam int ENTRY_LIMIT  = 2000;               // cycles per fifo entry
    localparam int POLL_LIMIT   = 400;                // status reads
    localparam int QUIET_CYCLES = 16;

    logic               clk1;
    logic               reset;
    logic               cyc;
    logic               stb;
    logic               we;
    logic [BUS_AW-1:0]  adr;
    logic [CMD_W-1:0]   dat_w;
    logic [CMD_W-1:0]   dat_r;
    logic               ack;
    logic               rd_en;
    logic [ENTRY_W-1:0] dout;
    logic               empty;

    logic [ENTRY_W-1:0] expect_q[$];                  // entries still to come out
    logic               random_gaps;

    gl_core dut0 (.clk1, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
                  .rd_en, .dout, .empty);

    initial
    begin
        clk1 = 1'b0;
        forever #4 clk1 = ~clk1;
    end

    ////////////////////
    // compare tasks
    task automatic stop_run(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_entry(input string name, input logic [ENTRY_W-1:0] got,
                               input logic [ENTRY_W-1:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_run("fifo entry mismatch");
        end
    endtask

    task automatic check_status(input string name, input logic [CMD_W-1:0] got,
                                input logic [CMD_W-1:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_run("bus read mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
            stop_run("flag mismatch");
        end
    endtask

    ////////////////////
    // wishbone host
    task automatic bus_cycle(input logic write, input logic [BUS_AW-1:0] addr,
                             input logic [CMD_W-1:0] data, output logic [CMD_W-1:0] rdata);
        int n;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = data;
        n     = 0;
        @(negedge clk1);
        while (!ack)
        begin
            n++;
            if (n > ACK_LIMIT)
                stop_run("bus cycle never got an ack");
            @(negedge clk1);
        end
        rdata = dat_r;
        @(negedge clk1);                              // stb held through the ack edge
        check_flag("ack", ack, 1'b0);                 // exactly one ack
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wait_idle();
        logic [CMD_W-1:0] st;
        int polls;
        polls = 0;
        bus_cycle(1'b0, CTRL_ADDR, '0, st);
        while (st[0])
        begin
            polls++;
            if (polls > POLL_LIMIT)
                stop_run("busy never cleared");
            bus_cycle(1'b0, CTRL_ADDR, '0, st);
        end
    endtask

    ////////////////////
    // fifo consumer
    task automatic wait_entry();
        int n;
        n = 0;
        while (empty)
        begin
            n++;
            if (n > ENTRY_LIMIT)
                stop_run("expected fifo entry never arrived");
            @(negedge clk1);
        end
    endtask

    task automatic drain_expected();
        logic [ENTRY_W-1:0] exp;
        int gap;
        while (expect_q.size() > 0)
        begin
            exp = expect_q.pop_front();
            gap = random_gaps ? int'($urandom % 4) : 0;
            repeat (gap) @(negedge clk1);
            wait_entry();
            check_entry("dout", dout, exp);
            rd_en = 1'b1;                             // pop on the next edge
            @(negedge clk1);
            rd_en = 1'b0;
        end
    endtask

    task automatic check_quiet();
        repeat (QUIET_CYCLES)
        begin
            @(negedge clk1);
            check_flag("empty", empty, 1'b1);
        end
    endtask

    // one line of the test file
    task automatic run_line(input string line);
        byte code;
        logic [63:0] a, b, c, d;
        logic [CMD_W-1:0] rdata;
        int nf;
        code = line.getc(0);
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        nf = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
        case (code)
            "W": bus_cycle(1'b1, a[BUS_AW-1:0], b[CMD_W-1:0], rdata);
            "R":
            begin
                bus_cycle(1'b0, a[BUS_AW-1:0], '0, rdata);
                check_status("dat_r", rdata, b[CMD_W-1:0]);
            end
            "V":
            begin
                if (nf != 4)
                    stop_run("vertex line needs four fields");
                bus_cycle(1'b1, a[BUS_AW-1:0], b[CMD_W-1:0], rdata);
                bus_cycle(1'b1, a[BUS_AW-1:0] + 1'b1, c[CMD_W-1:0], rdata);
                expect_q.push_back(d);
            end
            "Q": expect_q.push_back(a);
            "S": bus_cycle(1'b1, CTRL_ADDR, 32'h1, rdata);
            "I": repeat (a[15:0]) @(negedge clk1);
            "B": wait_idle();
            "M": random_gaps = a[0];
            "D": drain_expected();
            "Z": check_quiet();
            "#", " ", 8'h0a: ;                        // comment or blank
            default: stop_run("unknown command in test file");
        endcase
    endtask

    ////////////////////
    // sequencer
    initial
    begin
        int fd;
        string line;
        reset       = 1'b1;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        rd_en       = 1'b0;
        random_gaps = 1'b0;
        void'($urandom(88));                          // gap lengths repeat run to run
        repeat (10) @(posedge clk1);
        @(negedge clk1);
        reset = 1'b0;
        @(negedge clk1);
        check_flag("empty", empty, 1'b1);
        check_flag("ack", ack, 1'b0);

        fd = $fopen("test/gl_core_tests.txt", "r");
        if (fd == 0)
            stop_run("cannot open test/gl_core_tests.txt");
        while ($fgets(line, fd) > 0)
            run_line(line);
        $fclose(fd);

        if (expect_q.size() != 0)
            stop_run("expected entries left unchecked at end of file");
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* test/gl_core_tests.txt */
# columns: op, then hex fields. W adr data | R adr expected | V adr op_word coord_word entry
# Q entry | S start | I idle cycles | B wait busy low | M gaps 0/1 | D drain | Z fifo stays empty
R 100 00000000
W 000 00000001
W 001 000a0014
W 002 00000002
W 003 00500030
W 004 007c0003
V 005 00123404 00000000 7c0012340044005a
V 007 00010004 4000c000 7c000100001400aa
W 009 0003e003
V 00a 00020004 20002000 03e00200005c0082
W 00c 00000005
Q ffffffffffffffff
W 00d 00000001
W 00e 0100fff0
V 00f 00ffff04 e0001000 03e0ffff002c0128
W 011 000000ff
R 003 00000000
M 0
S
R 100 00000001
S
B
D
Z
# back-pressure, 24 vertices with no reads until the fifo is full
W 000 00000001
W 001 00000000
W 002 00000002
W 003 40002000
W 004 00123403
V 005 00010004 0000ffff 123401001fff4000
V 007 00010104 0100fdff 123401011eff4100
V 009 00010204 0200fbff 123401021dff4200
V 00b 00010304 0300f9ff 123401031cff4300
V 00d 00010404 0400f7ff 123401041bff4400
V 00f 00010504 0500f5ff 123401051aff4500
V 011 00010604 0600f3ff 1234010619ff4600
V 013 00010704 0700f1ff 1234010718ff4700
V 015 00010804 0800efff 1234010817ff4800
V 017 00010904 0900edff 1234010916ff4900
V 019 00010a04 0a00ebff 1234010a15ff4a00
V 01b 00010b04 0b00e9ff 1234010b14ff4b00
V 01d 00010c04 0c00e7ff 1234010c13ff4c00
V 01f 00010d04 0d00e5ff 1234010d12ff4d00
V 021 00010e04 0e00e3ff 1234010e11ff4e00
V 023 00010f04 0f00e1ff 1234010f10ff4f00
V 025 00011004 1000dfff 123401100fff5000
V 027 00011104 1100ddff 123401110eff5100
V 029 00011204 1200dbff 123401120dff5200
V 02b 00011304 1300d9ff 123401130cff5300
V 02d 00011404 1400d7ff 123401140bff5400
V 02f 00011504 1500d5ff 123401150aff5500
V 031 00011604 1600d3ff 1234011609ff5600
V 033 00011704 1700d1ff 1234011708ff5700
W 035 000000ff
S
I c8
R 100 00000001
M 1
D
B
R 100 00000000
Z

/* compile.f */
hw/gl_isa_pkg.sv
hw/gl_geom_pkg.sv
hw/wb_host_port.sv
hw/cmd_mem.sv
hw/cmd_fetch.sv
hw/cmd_decode.sv
hw/viewport_xform.sv
hw/vertex_fifo.sv
hw/gl_core.sv
test/tb_gl_core.sv

/* Makefile */
SIM = obj_dir/Vtb_gl_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_gl_core -f compile.f

run: compile
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
